// ==== rp_pkg.sv ====
//********************
// Shared definitions for the root-port message block
// Receive state type, CRA register offsets, TLP entry widths
//********************

package rp_pkg;

   // Completion unpacking states
   typedef enum logic [2:0]
   {
      IDLE    = 3'd0,
      RDFIFO  = 3'd1,   // Pop one entry
      PIPE    = 3'd2,   // FIFO output settles
      LD_REG0 = 3'd3,
      WAIT0   = 3'd4,   // Lower half visible to host
      LD_REG1 = 3'd5,
      WAIT1   = 3'd6    // Upper half visible to host
   } rxcpl_state_e;

   // Write-only transmit registers
   localparam logic [15:0] TX_DATA_LO_ADDR = 16'h2000;
   localparam logic [15:0] TX_DATA_HI_ADDR = 16'h2004;
   localparam logic [15:0] TX_CTRL_ADDR    = 16'h2008;

   // Read-only receive registers
   localparam logic [15:0] RX_STATUS_ADDR  = 16'h2010;
   localparam logic [15:0] RX_DATA_LO_ADDR = 16'h2014;
   localparam logic [15:0] RX_DATA_HI_ADDR = 16'h2018;

   // Entry layout is {empty, eop, sop, data[127:0]}
   localparam int TLP_W  = 131;
   localparam int HALF_W = 64;

   // Flag positions in the transmit control register
   localparam int TX_SOP_BIT = 0;
   localparam int TX_EOP_BIT = 1;

endpackage

// ==== rp_sync_fifo.sv ====
//********************
// Behavioural synchronous FIFO
// Registered read data, empty flag, fill count
//********************

module rp_sync_fifo #(
   parameter int WIDTH = 64,
   parameter int DEPTH = 16
) (
   input  logic                   CraClk_i,
   input  logic                   CraRstn_i,
   input  logic                   wr_i,
   input  logic [WIDTH-1:0]       wdata_i,
   input  logic                   rd_i,
   output logic [WIDTH-1:0]       rdata_o,
   output logic                   empty_o,
   output logic [$clog2(DEPTH):0] usedw_o
);

   localparam int AW = $clog2(DEPTH);

   logic [WIDTH-1:0] mem [DEPTH];
   logic [AW-1:0]    wr_ptr;
   logic [AW-1:0]    rd_ptr;
   logic [AW:0]      count;
   logic             full;
   logic             do_wr;
   logic             do_rd;

   assign full    = (count == (AW+1)'(DEPTH));
   assign empty_o = (count == '0);
   assign usedw_o = count;
   assign do_wr   = wr_i & ~full;      // Overflow dropped
   assign do_rd   = rd_i & ~empty_o;   // Underflow ignored

   always_ff @(posedge CraClk_i)
   begin
      if (do_wr)
         mem[wr_ptr] <= wdata_i;
   end

   always_ff @(posedge CraClk_i or negedge CraRstn_i)
   begin
      if (!CraRstn_i)
      begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         count   <= '0;
         rdata_o <= '0;
      end
      else
      begin
         if (do_wr)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_rd)
         begin
            rd_ptr  <= rd_ptr + 1'b1;
            rdata_o <= mem[rd_ptr];   // Valid one cycle after rd_i
         end
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

// ==== rp_cra_decode.sv ====
//********************
// CRA address decode
// Write strobes, registered read mux, read valid
//********************

module rp_cra_decode (
   input  logic        CraClk_i,
   input  logic        CraRstn_i,
   input  logic [13:2] IcrAddress_i,
   input  logic        RpWriteReqVld_i,
   input  logic        RpReadReqVld_i,
   input  logic [31:0] status_word_i,
   input  logic [31:0] data_lo_word_i,
   input  logic [31:0] data_hi_word_i,
   output logic        tx_lo_wr_o,
   output logic        tx_hi_wr_o,
   output logic        tx_ctl_wr_o,
   output logic        hi_read_o,
   output logic        status_read_o,
   output logic [31:0] RpReadData_o,
   output logic        RpReadDataVld_o
);

   // Reads only look at the low address byte
   localparam logic [7:0] STATUS_OFFS  = rp_pkg::RX_STATUS_ADDR[7:0];
   localparam logic [7:0] DATA_LO_OFFS = rp_pkg::RX_DATA_LO_ADDR[7:0];
   localparam logic [7:0] DATA_HI_OFFS = rp_pkg::RX_DATA_HI_ADDR[7:0];

   logic [15:0] byte_addr;
   logic [31:0] rd_mux;
   logic        status_sel_q;   // Pending read targets status

   assign byte_addr = {2'b00, IcrAddress_i, 2'b00};

   assign tx_lo_wr_o  = RpWriteReqVld_i & (byte_addr == rp_pkg::TX_DATA_LO_ADDR);
   assign tx_hi_wr_o  = RpWriteReqVld_i & (byte_addr == rp_pkg::TX_DATA_HI_ADDR);
   assign tx_ctl_wr_o = RpWriteReqVld_i & (byte_addr == rp_pkg::TX_CTRL_ADDR);

   // Upper data read advances the unpacker
   assign hi_read_o     = RpReadReqVld_i & (byte_addr[7:0] == DATA_HI_OFFS);
   assign status_read_o = RpReadDataVld_o & status_sel_q;

   always_comb
   begin
      case (byte_addr[7:0])
         STATUS_OFFS:  rd_mux = status_word_i;
         DATA_LO_OFFS: rd_mux = data_lo_word_i;
         DATA_HI_OFFS: rd_mux = data_hi_word_i;
         default:      rd_mux = 32'h0;   // Unmapped
      endcase
   end

   always_ff @(posedge CraClk_i or negedge CraRstn_i)
   begin
      if (!CraRstn_i)
      begin
         RpReadData_o    <= 32'h0;
         RpReadDataVld_o <= 1'b0;
         status_sel_q    <= 1'b0;
      end
      else
      begin
         RpReadDataVld_o <= RpReadReqVld_i;
         if (RpReadReqVld_i)
         begin
            RpReadData_o <= rd_mux;   // Sampled at request time
            status_sel_q <= (byte_addr[7:0] == STATUS_OFFS);
         end
      end
   end

endmodule

// ==== rp_tx_tlp_writer.sv ====
//********************
// Transmit TLP writer
// Data and control registers, half toggle, two FIFOs
//********************

module rp_tx_tlp_writer #(
   parameter int FIFO_DEPTH = 16
) (
   input  logic                     CraClk_i,
   input  logic                     CraRstn_i,
   input  logic [31:0]              IcrWriteData_i,
   input  logic [3:0]               IcrByteEnable_i,
   input  logic                     tx_lo_wr_i,
   input  logic                     tx_hi_wr_i,
   input  logic                     tx_ctl_wr_i,
   input  logic                     TxRpFifoRdReq_i,
   output logic [rp_pkg::TLP_W-1:0] TxRpFifoData_o,
   output logic                     RpTLPReady_o
);

   localparam int LO_W = rp_pkg::HALF_W;
   localparam int HI_W = rp_pkg::TLP_W - rp_pkg::HALF_W;   // Half plus three flags
   localparam int UW   = $clog2(FIFO_DEPTH) + 1;

   logic [31:0]   tx_lo_q;
   logic [31:0]   tx_hi_q;
   logic [31:0]   tx_ctl_q;
   logic          ctl_wr_q;       // Push happens the edge after a control write
   logic          toggle_q;       // 0 selects the lower FIFO
   logic          tx_sop;
   logic          tx_eop;
   logic          tx_empty;
   logic          lo_wr;
   logic          hi_wr;
   logic [LO_W-1:0] lo_wdata;
   logic [HI_W-1:0] hi_wdata;
   logic [LO_W-1:0] lo_rdata;
   logic [HI_W-1:0] hi_rdata;
   logic            hi_empty;
   logic [UW-1:0]   hi_used;

   // Replace only the enabled bytes
   function automatic logic [31:0] be_merge(input logic [31:0] cur,
                                            input logic [31:0] wdat,
                                            input logic [3:0]  be);
      logic [31:0] res;
      res = cur;
      for (int i = 0; i < 4; i++)
      begin
         if (be[i])
            res[8*i +: 8] = wdat[8*i +: 8];
      end
      return res;
   endfunction

   always_ff @(posedge CraClk_i or negedge CraRstn_i)
   begin
      if (!CraRstn_i)
      begin
         tx_lo_q  <= 32'h0;
         tx_hi_q  <= 32'h0;
         tx_ctl_q <= 32'h0;
         ctl_wr_q <= 1'b0;
         toggle_q <= 1'b0;
      end
      else
      begin
         if (tx_lo_wr_i)
            tx_lo_q <= be_merge(tx_lo_q, IcrWriteData_i, IcrByteEnable_i);
         if (tx_hi_wr_i)
            tx_hi_q <= be_merge(tx_hi_q, IcrWriteData_i, IcrByteEnable_i);
         if (tx_ctl_wr_i)
            tx_ctl_q <= be_merge(tx_ctl_q, IcrWriteData_i, IcrByteEnable_i);
         ctl_wr_q <= tx_ctl_wr_i;
         if (ctl_wr_q & tx_eop)
            toggle_q <= 1'b0;          // Next packet starts on the lower FIFO
         else if (ctl_wr_q)
            toggle_q <= ~toggle_q;
      end
   end

   assign tx_sop   = tx_ctl_q[rp_pkg::TX_SOP_BIT];
   assign tx_eop   = tx_ctl_q[rp_pkg::TX_EOP_BIT];
   assign tx_empty = tx_eop & ~toggle_q;   // EOP on a lower half

   assign lo_wr    = ctl_wr_q & ~toggle_q;
   assign hi_wr    = ctl_wr_q & (toggle_q | tx_eop);
   assign lo_wdata = {tx_hi_q, tx_lo_q};
   assign hi_wdata = {tx_empty, tx_eop, tx_sop, tx_hi_q, tx_lo_q};

   rp_sync_fifo #(.WIDTH(LO_W), .DEPTH(FIFO_DEPTH)) u_lo_fifo (
      .CraClk_i (CraClk_i),
      .CraRstn_i(CraRstn_i),
      .wr_i     (lo_wr),
      .wdata_i  (lo_wdata),
      .rd_i     (TxRpFifoRdReq_i),
      .rdata_o  (lo_rdata),
      .empty_o  (),
      .usedw_o  ()
   );

   rp_sync_fifo #(.WIDTH(HI_W), .DEPTH(FIFO_DEPTH)) u_hi_fifo (
      .CraClk_i (CraClk_i),
      .CraRstn_i(CraRstn_i),
      .wr_i     (hi_wr),
      .wdata_i  (hi_wdata),
      .rd_i     (TxRpFifoRdReq_i),
      .rdata_o  (hi_rdata),
      .empty_o  (hi_empty),
      .usedw_o  (hi_used)
   );

   assign TxRpFifoData_o = {hi_rdata, lo_rdata};
   assign RpTLPReady_o   = (tx_eop & ~hi_empty) | (hi_used >= UW'(2));

endmodule

// ==== rp_rx_cpl_reader.sv ====
//********************
// Receive completion reader
// Receive FIFO, unpacking FSM, status and data registers
//********************

module rp_rx_cpl_reader #(
   parameter int FIFO_DEPTH = 16
) (
   input  logic                     CraClk_i,
   input  logic                     CraRstn_i,
   input  logic                     RxRpFifoWrReq_i,
   input  logic [rp_pkg::TLP_W-1:0] RxRpFifoWrData_i,
   input  logic                     hi_read_i,
   input  logic                     status_read_i,
   output logic [31:0]              status_word_o,
   output logic [31:0]              data_lo_word_o,
   output logic [31:0]              data_hi_word_o
);

   localparam int UW      = $clog2(FIFO_DEPTH) + 1;
   localparam int SOP_POS = 2 * rp_pkg::HALF_W;
   localparam int EOP_POS = SOP_POS + 1;
   localparam int EMP_POS = SOP_POS + 2;

   rp_pkg::rxcpl_state_e rxcpl_state;
   rp_pkg::rxcpl_state_e rxcpl_nxt_state;

   logic [rp_pkg::TLP_W-1:0] fifo_rdata;
   logic                     fifo_empty;
   logic [UW-1:0]            fifo_used;
   logic                     fifo_rd;
   logic                     load_lo;
   logic                     load_hi;
   logic                     cpl_sop;
   logic                     cpl_eop;
   logic                     cpl_empty;
   logic [31:0]              data_lo_q;
   logic [31:0]              data_hi_q;
   logic                     sop_q;
   logic                     eop_q;
   logic [7:0]               used_q;

   rp_sync_fifo #(.WIDTH(rp_pkg::TLP_W), .DEPTH(FIFO_DEPTH)) u_rx_fifo (
      .CraClk_i (CraClk_i),
      .CraRstn_i(CraRstn_i),
      .wr_i     (RxRpFifoWrReq_i),
      .wdata_i  (RxRpFifoWrData_i),
      .rd_i     (fifo_rd),
      .rdata_o  (fifo_rdata),
      .empty_o  (fifo_empty),
      .usedw_o  (fifo_used)
   );

   assign cpl_sop   = fifo_rdata[SOP_POS];
   assign cpl_eop   = fifo_rdata[EOP_POS];
   assign cpl_empty = fifo_rdata[EMP_POS];

   always_ff @(posedge CraClk_i or negedge CraRstn_i)
   begin
      if (!CraRstn_i)
         rxcpl_state <= rp_pkg::IDLE;
      else
         rxcpl_state <= rxcpl_nxt_state;
   end

   always_comb
   begin
      rxcpl_nxt_state = rxcpl_state;
      case (rxcpl_state)
         rp_pkg::IDLE:    if (!fifo_empty) rxcpl_nxt_state = rp_pkg::RDFIFO;
         rp_pkg::RDFIFO:  rxcpl_nxt_state = rp_pkg::PIPE;
         rp_pkg::PIPE:    rxcpl_nxt_state = rp_pkg::LD_REG0;
         rp_pkg::LD_REG0: rxcpl_nxt_state = rp_pkg::WAIT0;
         rp_pkg::WAIT0:
            if (hi_read_i)   // Skip the upper half if it is empty
               rxcpl_nxt_state = (cpl_eop & cpl_empty) ? rp_pkg::IDLE : rp_pkg::LD_REG1;
         rp_pkg::LD_REG1: rxcpl_nxt_state = rp_pkg::WAIT1;
         rp_pkg::WAIT1:
            if (hi_read_i)
               rxcpl_nxt_state = cpl_eop ? rp_pkg::IDLE : rp_pkg::RDFIFO;
         default:         rxcpl_nxt_state = rp_pkg::IDLE;
      endcase
   end

   assign fifo_rd = (rxcpl_state == rp_pkg::RDFIFO);
   assign load_lo = (rxcpl_state == rp_pkg::LD_REG0);
   assign load_hi = (rxcpl_state == rp_pkg::LD_REG1);

   always_ff @(posedge CraClk_i or negedge CraRstn_i)
   begin
      if (!CraRstn_i)
      begin
         data_lo_q <= 32'h0;
         data_hi_q <= 32'h0;
         sop_q     <= 1'b0;
         eop_q     <= 1'b0;
         used_q    <= 8'h0;
      end
      else
      begin
         if (load_lo)
         begin
            data_lo_q <= fifo_rdata[31:0];
            data_hi_q <= fifo_rdata[63:32];
         end
         else if (load_hi)
         begin
            data_lo_q <= fifo_rdata[95:64];
            data_hi_q <= fifo_rdata[127:96];
         end
         // SOP only belongs to the first half
         if (load_lo & cpl_sop)
            sop_q <= 1'b1;
         else if (load_hi | status_read_i)
            sop_q <= 1'b0;
         // EOP shows on whichever half is the last
         if ((load_lo & cpl_eop & cpl_empty) | (load_hi & cpl_eop & ~cpl_empty))
            eop_q <= 1'b1;
         else if (load_lo | status_read_i)
            eop_q <= 1'b0;
         if (fifo_rd)
            used_q <= {{(8-UW){1'b0}}, fifo_used};   // Count before the pop
      end
   end

   assign status_word_o  = {16'h0, used_q, 6'h0, eop_q, sop_q};
   assign data_lo_word_o = data_lo_q;
   assign data_hi_word_o = data_hi_q;

endmodule

// ==== rp_tlp_bridge_top.sv ====
//********************
// Root-port message block top
// CRA decoder, TLP writer, completion reader
//********************

module rp_tlp_bridge_top #(
   parameter int FIFO_DEPTH = 16
) (
   input  logic                     CraClk_i,
   input  logic                     CraRstn_i,
   input  logic [13:2]              IcrAddress_i,
   input  logic [31:0]              IcrWriteData_i,
   input  logic [3:0]               IcrByteEnable_i,
   input  logic                     RpWriteReqVld_i,
   input  logic                     RpReadReqVld_i,
   output logic [31:0]              RpReadData_o,
   output logic                     RpReadDataVld_o,
   input  logic                     TxRpFifoRdReq_i,
   output logic [rp_pkg::TLP_W-1:0] TxRpFifoData_o,
   output logic                     RpTLPReady_o,
   input  logic                     RxRpFifoWrReq_i,
   input  logic [rp_pkg::TLP_W-1:0] RxRpFifoWrData_i
);

   logic        tx_lo_wr;
   logic        tx_hi_wr;
   logic        tx_ctl_wr;
   logic        hi_read;
   logic        status_read;
   logic [31:0] status_word;
   logic [31:0] data_lo_word;
   logic [31:0] data_hi_word;

   rp_cra_decode u_decode (
      .CraClk_i(CraClk_i), .CraRstn_i(CraRstn_i), .IcrAddress_i(IcrAddress_i),
      .RpWriteReqVld_i(RpWriteReqVld_i), .RpReadReqVld_i(RpReadReqVld_i),
      .status_word_i(status_word), .data_lo_word_i(data_lo_word),
      .data_hi_word_i(data_hi_word), .tx_lo_wr_o(tx_lo_wr), .tx_hi_wr_o(tx_hi_wr),
      .tx_ctl_wr_o(tx_ctl_wr), .hi_read_o(hi_read), .status_read_o(status_read),
      .RpReadData_o(RpReadData_o), .RpReadDataVld_o(RpReadDataVld_o)
   );

   rp_tx_tlp_writer #(.FIFO_DEPTH(FIFO_DEPTH)) u_tx_writer (
      .CraClk_i(CraClk_i), .CraRstn_i(CraRstn_i), .IcrWriteData_i(IcrWriteData_i),
      .IcrByteEnable_i(IcrByteEnable_i), .tx_lo_wr_i(tx_lo_wr), .tx_hi_wr_i(tx_hi_wr),
      .tx_ctl_wr_i(tx_ctl_wr), .TxRpFifoRdReq_i(TxRpFifoRdReq_i),
      .TxRpFifoData_o(TxRpFifoData_o), .RpTLPReady_o(RpTLPReady_o)
   );

   rp_rx_cpl_reader #(.FIFO_DEPTH(FIFO_DEPTH)) u_rx_reader (
      .CraClk_i(CraClk_i), .CraRstn_i(CraRstn_i), .RxRpFifoWrReq_i(RxRpFifoWrReq_i),
      .RxRpFifoWrData_i(RxRpFifoWrData_i), .hi_read_i(hi_read),
      .status_read_i(status_read), .status_word_o(status_word),
      .data_lo_word_o(data_lo_word), .data_hi_word_o(data_hi_word)
   );

endmodule

// ==== tb_rp_bridge_assert.sv ====
//********************
// Concurrent protocol checks on the bridge top
// Read-valid timing, reset values, short FSM states
//********************

module tb_rp_bridge_assert (
   input logic                 CraClk_i,
   input logic                 CraRstn_i,
   input logic                 rd_req_i,
   input logic                 rd_vld_i,
   input logic                 tlp_ready_i,
   input rp_pkg::rxcpl_state_e rx_state_i
);

   int failures = 0;

   a_vld_after_req : assert property (@(posedge CraClk_i) disable iff (!CraRstn_i)
      rd_req_i |=> rd_vld_i)
   else
   begin
      $error("Read-valid missing one cycle after a read request");
      failures++;
   end

   a_vld_only_after_req : assert property (@(posedge CraClk_i) disable iff (!CraRstn_i)
      rd_vld_i |-> $past(rd_req_i))
   else
   begin
      $error("Read-valid raised without a read request one cycle before");
      failures++;
   end

   // Also covers the first cycle out of reset
   a_reset_quiet : assert property (@(posedge CraClk_i)
      (!CraRstn_i || $rose(CraRstn_i)) |-> (!tlp_ready_i && rx_state_i == rp_pkg::IDLE))
   else
   begin
      $error("TLP ready high or receive FSM not idle around reset");
      failures++;
   end

   a_short_states : assert property (@(posedge CraClk_i) disable iff (!CraRstn_i)
      (rx_state_i inside {rp_pkg::RDFIFO, rp_pkg::PIPE, rp_pkg::LD_REG0, rp_pkg::LD_REG1})
      |=> (rx_state_i != $past(rx_state_i)))
   else
   begin
      $error("Receive FSM held a one-cycle state for longer");
      failures++;
   end

endmodule

bind rp_tlp_bridge_top tb_rp_bridge_assert u_bridge_assert (
   .CraClk_i   (CraClk_i),
   .CraRstn_i  (CraRstn_i),
   .rd_req_i   (RpReadReqVld_i),
   .rd_vld_i   (RpReadDataVld_o),
   .tlp_ready_i(RpTLPReady_o),
   .rx_state_i (u_rx_reader.rxcpl_state)
);

// ==== tb_rp_bridge.sv ====
//********************
// Testbench for the root-port message block
// Clock, reset, CRA tasks, transmit and receive models
//********************

module tb_rp_bridge;

   localparam int WAIT_LIMIT = 100;   // Cycles per wait loop
   localparam int POLL_LIMIT = 20;    // Reads per polling loop

   logic                     clk = 1'b0;
   logic                     rstn;
   logic [13:2]              icr_addr;
   logic [31:0]              icr_wdata;
   logic [3:0]               icr_be;
   logic                     wr_req;
   logic                     rd_req;
   logic [31:0]              rd_data;
   logic                     rd_vld;
   logic                     tx_rd_req;
   logic [rp_pkg::TLP_W-1:0] tx_data;
   logic                     tlp_ready;
   logic                     rx_wr_req;
   logic [rp_pkg::TLP_W-1:0] rx_wr_data;

   rp_tlp_bridge_top #(.FIFO_DEPTH(16)) uut (
      .CraClk_i        (clk),
      .CraRstn_i       (rstn),
      .IcrAddress_i    (icr_addr),
      .IcrWriteData_i  (icr_wdata),
      .IcrByteEnable_i (icr_be),
      .RpWriteReqVld_i (wr_req),
      .RpReadReqVld_i  (rd_req),
      .RpReadData_o    (rd_data),
      .RpReadDataVld_o (rd_vld),
      .TxRpFifoRdReq_i (tx_rd_req),
      .TxRpFifoData_o  (tx_data),
      .RpTLPReady_o    (tlp_ready),
      .RxRpFifoWrReq_i (rx_wr_req),
      .RxRpFifoWrData_i(rx_wr_data)
   );

   initial
   begin
      forever #20 clk = ~clk;
   end

   task automatic halt_run(input string why);
      $display("%s", why);
      $display("Testbench failed");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   // Any bound checker hit ends the run
   always @(negedge clk)
   begin
      if (uut.u_bridge_assert.failures != 0)
         halt_run("A protocol assertion on the DUT failed");
   end

   // Byte enables expanded to a bit mask
   function automatic logic [31:0] lane_mask(input logic [3:0] be);
      return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
   endfunction

   function automatic logic [rp_pkg::TLP_W-1:0] random_cpl(input logic empty,
                                                           input logic eop,
                                                           input logic sop);
      return {empty, eop, sop, $urandom, $urandom, $urandom, $urandom};
   endfunction

   task automatic cra_write(input logic [15:0] addr, input logic [31:0] data,
                            input logic [3:0] be);
      @(negedge clk);
      icr_addr  = addr[13:2];
      icr_wdata = data;
      icr_be    = be;
      wr_req    = 1'b1;
      @(negedge clk);
      wr_req    = 1'b0;
   endtask

   task automatic fetch_word(input logic [15:0] addr, output logic [31:0] data);
      int waited;
      waited = 0;
      @(negedge clk);
      icr_addr = addr[13:2];
      rd_req   = 1'b1;
      @(negedge clk);
      rd_req   = 1'b0;
      while (!rd_vld)
      begin
         if (waited == WAIT_LIMIT)
            halt_run($sformatf("Read of address %h never returned read-valid", addr));
         waited++;
         @(negedge clk);
      end
      data = rd_data;
   endtask

   task automatic cra_read(input logic [15:0] addr, input logic [31:0] exp);
      logic [31:0] got;
      fetch_word(addr, got);
      assert (got === exp)
      else
         halt_run($sformatf("** Error at time %0t: read of %h returned %h, expected %h",
                            $time, addr, got, exp));
   endtask

   // Lower data register has no side effects so it can be polled
   task automatic poll_until(input logic [15:0] addr, input logic [31:0] exp);
      logic [31:0] got;
      int          tries;
      tries = 0;
      fetch_word(addr, got);
      while (got !== exp)
      begin
         if (tries == POLL_LIMIT)
            halt_run($sformatf("Register %h never showed the value %h", addr, exp));
         tries++;
         fetch_word(addr, got);
      end
   endtask

   task automatic wait_ready();
      int waited;
      waited = 0;
      while (!tlp_ready)
      begin
         if (waited == WAIT_LIMIT)
            halt_run("RpTLPReady_o never rose after the packet was written");
         waited++;
         @(negedge clk);
      end
   endtask

   task automatic check_ready(input logic exp, input string when);
      assert (tlp_ready === exp)
      else
         halt_run($sformatf("** Error at time %0t: RpTLPReady_o is %b %s, expected %b",
                            $time, tlp_ready, when, exp));
   endtask

   // One 64-bit half followed by its control write
   task automatic send_half(input logic sop, input logic eop, output logic [63:0] half);
      logic [31:0] lo;
      logic [31:0] hi;
      logic [31:0] ctl;
      lo  = $urandom;
      hi  = $urandom;
      ctl = 32'h0;
      ctl[rp_pkg::TX_SOP_BIT] = sop;
      ctl[rp_pkg::TX_EOP_BIT] = eop;
      cra_write(rp_pkg::TX_DATA_LO_ADDR, lo, 4'hF);
      cra_write(rp_pkg::TX_DATA_HI_ADDR, hi, 4'hF);
      cra_write(rp_pkg::TX_CTRL_ADDR, ctl, 4'hF);
      half = {hi, lo};
   endtask

   task automatic pop_entry(input logic [rp_pkg::TLP_W-1:0] exp);
      @(negedge clk);
      tx_rd_req = 1'b1;
      @(negedge clk);
      tx_rd_req = 1'b0;   // Entry now held on the output
      assert (tx_data === exp)
      else
         halt_run($sformatf("** Error at time %0t: popped entry %h, expected %h",
                            $time, tx_data, exp));
   endtask

   // Two back-to-back writes into the receive FIFO
   task automatic push_pair(input logic [rp_pkg::TLP_W-1:0] first,
                            input logic [rp_pkg::TLP_W-1:0] second);
      @(negedge clk);
      rx_wr_req  = 1'b1;
      rx_wr_data = first;
      @(negedge clk);
      rx_wr_data = second;
      @(negedge clk);
      rx_wr_req  = 1'b0;
   endtask

   initial
   begin
      logic [63:0]              h0;
      logic [63:0]              h1;
      logic [63:0]              h2;
      logic [63:0]              h3;
      logic [31:0]              lo_a;
      logic [31:0]              lo_b;
      logic [31:0]              hi_a;
      logic [31:0]              hi_b;
      logic [31:0]              lo_exp;
      logic [31:0]              hi_exp;
      logic [rp_pkg::TLP_W-1:0] e0;
      logic [rp_pkg::TLP_W-1:0] e1;
      logic [rp_pkg::TLP_W-1:0] e2;
      logic [rp_pkg::TLP_W-1:0] e3;

      rstn       = 1'b0;
      icr_addr   = '0;
      icr_wdata  = 32'h0;
      icr_be     = 4'h0;
      wr_req     = 1'b0;
      rd_req     = 1'b0;
      tx_rd_req  = 1'b0;
      rx_wr_req  = 1'b0;
      rx_wr_data = '0;
      void'($urandom(5413));
      repeat (16) @(negedge clk);
      rstn = 1'b1;

      // Registers come out of reset cleared
      cra_read(rp_pkg::RX_STATUS_ADDR, 32'h0);
      cra_read(rp_pkg::RX_DATA_LO_ADDR, 32'h0);
      cra_read(rp_pkg::RX_DATA_HI_ADDR, 32'h0);
      check_ready(1'b0, "after reset");

      // Four halves where entry flags follow the upper half's control write
      send_half(1'b1, 1'b0, h0);
      send_half(1'b1, 1'b0, h1);
      send_half(1'b0, 1'b0, h2);
      check_ready(1'b0, "before the EOP write");
      send_half(1'b0, 1'b1, h3);
      wait_ready();
      pop_entry({3'b001, h1, h0});
      pop_entry({3'b010, h3, h2});
      check_ready(1'b0, "after both pops");

      // EOP lands on a lower half
      send_half(1'b1, 1'b0, h0);
      send_half(1'b1, 1'b0, h1);
      send_half(1'b0, 1'b1, h2);
      wait_ready();
      pop_entry({3'b001, h1, h0});
      pop_entry({3'b110, h2, h2});

      // Byte 3 follows its own byte enable
      lo_a = $urandom;
      lo_b = $urandom;
      hi_a = $urandom;
      hi_b = $urandom;
      cra_write(rp_pkg::TX_DATA_LO_ADDR, lo_a, 4'hF);
      cra_write(rp_pkg::TX_DATA_LO_ADDR, lo_b, 4'b0101);
      cra_write(rp_pkg::TX_DATA_HI_ADDR, hi_a, 4'hF);
      cra_write(rp_pkg::TX_DATA_HI_ADDR, hi_b, 4'b1000);
      lo_exp = (lo_a & ~lane_mask(4'b0101)) | (lo_b & lane_mask(4'b0101));
      hi_exp = (hi_a & ~lane_mask(4'b1000)) | (hi_b & lane_mask(4'b1000));
      cra_write(rp_pkg::TX_CTRL_ADDR,
                (32'h1 << rp_pkg::TX_SOP_BIT) | (32'h1 << rp_pkg::TX_EOP_BIT), 4'hF);
      wait_ready();
      pop_entry({3'b111, hi_exp, lo_exp, hi_exp, lo_exp});

      // Two completion entries, SOP then EOP
      e0 = random_cpl(1'b0, 1'b0, 1'b1);
      e1 = random_cpl(1'b0, 1'b1, 1'b0);
      push_pair(e0, e1);
      poll_until(rp_pkg::RX_DATA_LO_ADDR, e0[31:0]);
      cra_read(rp_pkg::RX_STATUS_ADDR, 32'h0000_0201);
      cra_read(rp_pkg::RX_STATUS_ADDR, 32'h0000_0200);   // Flags cleared by the read
      cra_read(rp_pkg::RX_DATA_HI_ADDR, e0[63:32]);
      poll_until(rp_pkg::RX_DATA_LO_ADDR, e0[95:64]);
      cra_read(rp_pkg::RX_STATUS_ADDR, 32'h0000_0200);
      cra_read(rp_pkg::RX_DATA_HI_ADDR, e0[127:96]);
      poll_until(rp_pkg::RX_DATA_LO_ADDR, e1[31:0]);
      cra_read(rp_pkg::RX_STATUS_ADDR, 32'h0000_0100);
      cra_read(rp_pkg::RX_DATA_HI_ADDR, e1[63:32]);
      poll_until(rp_pkg::RX_DATA_LO_ADDR, e1[95:64]);
      cra_read(rp_pkg::RX_STATUS_ADDR, 32'h0000_0102);
      cra_read(rp_pkg::RX_STATUS_ADDR, 32'h0000_0100);
      cra_read(rp_pkg::RX_DATA_HI_ADDR, e1[127:96]);

      // EOP with an empty upper half skips straight back to IDLE
      e2 = random_cpl(1'b1, 1'b1, 1'b0);
      e3 = random_cpl(1'b1, 1'b1, 1'b1);
      push_pair(e2, e3);
      poll_until(rp_pkg::RX_DATA_LO_ADDR, e2[31:0]);
      cra_read(rp_pkg::RX_STATUS_ADDR, 32'h0000_0202);
      cra_read(rp_pkg::RX_DATA_HI_ADDR, e2[63:32]);
      poll_until(rp_pkg::RX_DATA_LO_ADDR, e3[31:0]);
      cra_read(rp_pkg::RX_STATUS_ADDR, 32'h0000_0103);
      cra_read(rp_pkg::RX_STATUS_ADDR, 32'h0000_0100);
      cra_read(rp_pkg::RX_DATA_HI_ADDR, e3[63:32]);

      repeat (4) @(negedge clk);
      if (uut.u_bridge_assert.failures == 0)
      begin
         $display("Testbench passed");
         $finish;
      end
      else
         halt_run("A protocol assertion on the DUT failed during the run");
   end

endmodule

// ==== build.f ====
rp_pkg.sv
rp_sync_fifo.sv
rp_cra_decode.sv
rp_tx_tlp_writer.sv
rp_rx_cpl_reader.sv
rp_tlp_bridge_top.sv
tb_rp_bridge_assert.sv
tb_rp_bridge.sv
